// ==== src/husky_macros.svh ====
`ifndef HUSKY_MACROS_SVH
`define HUSKY_MACROS_SVH

// byte index within one multi-byte register access
`define HUSKY_BYTECNT_SIZE 7

// sample FIFO entries, also the credits held by the capture side
`define HUSKY_FIFO_DEPTH 16

// must hold HUSKY_FIFO_DEPTH itself
`define HUSKY_CREDIT_W 5

// heartbeat bit that blinks the error LED
`define HUSKY_HEARTBEAT_BIT 22

`endif

// ==== src/usb_reg_pkg.sv ====
`default_nettype none

package usb_reg_pkg;

   // host bus access phase
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      WRITE = 2'd1,   // write strobe seen, waiting for it to rise
      READ  = 2'd2    // read strobe seen, waiting for it to rise
   } bus_state_e;

   // register map shared by all blocks on the bus
   typedef enum logic [7:0] {
      REG_ARM       = 8'h01,
      REG_TRIG_SRC  = 8'h02,
      REG_TRIG_MODE = 8'h03,
      REG_SAMPLES   = 8'h04,  // 16 bits, byte 0 is the low byte
      REG_STATUS    = 8'h05,
      REG_FIFO_DATA = 8'h06   // one sample byte per read
   } reg_addr_e;

endpackage

`default_nettype wire

// ==== src/capture_pkg.sv ====
`default_nettype none

package capture_pkg;

   // capture sequence
   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      ARMED   = 2'd1,   // waiting for trigger
      CAPTURE = 2'd2,   // one sample per cycle
      DONE    = 2'd3
   } cap_state_e;

   // how the selected target IO lines combine
   typedef enum logic {
      TRIG_OR  = 1'b0,
      TRIG_AND = 1'b1
   } trig_mode_e;

endpackage

`default_nettype wire

// ==== src/usb_reg_main.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "husky_macros.svh"

module usb_reg_main (
   input  wire                            clk_usb_buf,
   input  wire                            rst_i,
   input  wire  [7:0]                     usb_addr_i,
   input  wire  [7:0]                     usb_data_i,
   output logic [7:0]                     usb_data_o,
   output logic                           usb_data_oe_o,
   input  wire                            usb_rdn_i,
   input  wire                            usb_wrn_i,
   input  wire                            usb_cen_i,
   input  wire                            usb_alen_i,
   output logic [7:0]                     reg_address_o,
   output logic [`HUSKY_BYTECNT_SIZE-1:0] reg_bytecnt_o,
   output logic [7:0]                     reg_datao_o,
   input  wire  [7:0]                     reg_datai_i,
   output logic                           reg_read_o,
   output logic                           reg_write_o
);

   logic [7:0] addr_r;
   logic [7:0] data_r;
   logic       rdn_r;
   logic       wrn_r;
   logic       cen_r;
   logic       alen_r;
   logic       wr_start;
   logic       rd_start;
   usb_reg_pkg::bus_state_e state;

   always_ff @(posedge clk_usb_buf) begin
      addr_r <= usb_addr_i;
      data_r <= usb_data_i;
   end

   // strobes are active low, so they reset to the inactive level
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         rdn_r  <= 1'b1;
         wrn_r  <= 1'b1;
         cen_r  <= 1'b1;
         alen_r <= 1'b1;
      end else begin
         rdn_r  <= usb_rdn_i;
         wrn_r  <= usb_wrn_i;
         cen_r  <= usb_cen_i;
         alen_r <= usb_alen_i;
      end
   end

   // falling strobe only counts once the bus is back in IDLE
   assign wr_start = (state == usb_reg_pkg::IDLE) && !cen_r && !wrn_r;
   assign rd_start = (state == usb_reg_pkg::IDLE) && !cen_r && !rdn_r && wrn_r;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         state       <= usb_reg_pkg::IDLE;
         reg_write_o <= 1'b0;
         reg_read_o  <= 1'b0;
      end else begin
         reg_write_o <= wr_start;   // one-cycle strobes
         reg_read_o  <= rd_start;
         case (state)
            usb_reg_pkg::IDLE: begin
               if (wr_start) state <= usb_reg_pkg::WRITE;
               else if (rd_start) state <= usb_reg_pkg::READ;
            end
            usb_reg_pkg::WRITE: if (wrn_r) state <= usb_reg_pkg::IDLE;
            usb_reg_pkg::READ:  if (rdn_r) state <= usb_reg_pkg::IDLE;
            default: state <= usb_reg_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (wr_start) reg_datao_o <= data_r;   // lines up with reg_write_o
   end

   // address phase restarts the byte count, each access advances it
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         reg_address_o <= 8'h00;
         reg_bytecnt_o <= '0;
      end else if (!alen_r) begin
         reg_address_o <= addr_r;
         reg_bytecnt_o <= '0;
      end else if (reg_write_o || reg_read_o) begin
         reg_bytecnt_o <= reg_bytecnt_o + 1'b1;
      end
   end

   // read data held until the next read
   always_ff @(posedge clk_usb_buf) begin
      if (reg_read_o) usb_data_o <= reg_datai_i;
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) usb_data_oe_o <= 1'b0;
      else usb_data_oe_o <= !rdn_r && !cen_r;
   end

endmodule

`default_nettype wire

// ==== src/reg_trigger.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_trigger (
   input  wire        clk_usb_buf,
   input  wire        rst_i,
   input  wire  [7:0] reg_address_i,
   input  wire  [7:0] reg_datai_i,
   input  wire        reg_write_i,
   output logic [7:0] reg_datao_o,
   input  wire  [3:0] target_io_i,
   output logic       trigger_o
);

   logic [3:0] trig_src;   // one bit per target IO line
   logic [3:0] io_r;
   logic       any_hit;
   logic       all_hit;
   capture_pkg::trig_mode_e trig_mode;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         trig_src  <= 4'h0;
         trig_mode <= capture_pkg::TRIG_OR;
      end else if (reg_write_i) begin
         if (reg_address_i == usb_reg_pkg::REG_TRIG_SRC)
            trig_src <= reg_datai_i[3:0];
         if (reg_address_i == usb_reg_pkg::REG_TRIG_MODE)
            trig_mode <= capture_pkg::trig_mode_e'(reg_datai_i[0]);
      end
   end

   assign any_hit = |(io_r & trig_src);
   // unselected lines count as high, empty mask never fires
   assign all_hit = (|trig_src) && (&(io_r | ~trig_src));

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         io_r      <= 4'h0;
         trigger_o <= 1'b0;
      end else begin
         io_r <= target_io_i;
         if (trig_mode == capture_pkg::TRIG_AND) trigger_o <= all_hit;
         else trigger_o <= any_hit;
      end
   end

   always_comb begin
      reg_datao_o = 8'h00;
      case (reg_address_i)
         usb_reg_pkg::REG_TRIG_SRC:  reg_datao_o = {4'h0, trig_src};
         usb_reg_pkg::REG_TRIG_MODE: reg_datao_o = {7'h00, trig_mode};
         default: reg_datao_o = 8'h00;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/capture_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "husky_macros.svh"

module capture_ctrl (
   input  wire                           clk_usb_buf,
   input  wire                           rst_i,
   input  wire [7:0]                     reg_address_i,
   input  wire [`HUSKY_BYTECNT_SIZE-1:0] reg_bytecnt_i,
   input  wire [7:0]                     reg_datai_i,
   input  wire                           reg_write_i,
   output logic [7:0]                    reg_datao_o,
   input  wire                           trigger_i,
   input  wire [11:0]                    adc_data_i,
   output logic                          sample_valid_o,
   output logic [7:0]                    sample_data_o,
   input  wire                           credit_return_i,
   output logic                          led_armed_o,
   output logic                          led_cap_o,
   output logic                          led_err_o
);

   logic [15:0]                    num_samples;
   logic [15:0]                    sample_cnt;
   logic [`HUSKY_CREDIT_W-1:0]     credits;
   logic                           overflow;   // sticky until re-arm
   logic                           take;
   logic                           arm_wr;
   logic [`HUSKY_HEARTBEAT_BIT:0]  heartbeat;
   capture_pkg::cap_state_e        state;

   assign arm_wr = reg_write_i && (reg_address_i == usb_reg_pkg::REG_ARM) && reg_datai_i[0];
   assign take   = (state == capture_pkg::CAPTURE) && (credits != '0);

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) num_samples <= 16'h0000;
      else if (reg_write_i && (reg_address_i == usb_reg_pkg::REG_SAMPLES)) begin
         if (reg_bytecnt_i == 0) num_samples[7:0] <= reg_datai_i;
         else if (reg_bytecnt_i == 1) num_samples[15:8] <= reg_datai_i;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         state      <= capture_pkg::IDLE;
         sample_cnt <= 16'h0000;
         overflow   <= 1'b0;
      end else if (arm_wr) begin
         state    <= capture_pkg::ARMED;   // FIFO contents are kept
         overflow <= 1'b0;
      end else begin
         case (state)
            capture_pkg::ARMED: begin
               sample_cnt <= 16'h0000;
               if (trigger_i) begin
                  if (num_samples == 16'h0000) state <= capture_pkg::DONE;
                  else state <= capture_pkg::CAPTURE;
               end
            end
            capture_pkg::CAPTURE: begin
               if (!take) overflow <= 1'b1;   // no room, sample lost
               sample_cnt <= sample_cnt + 16'd1;
               if (sample_cnt == num_samples - 16'd1) state <= capture_pkg::DONE;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         credits        <= `HUSKY_CREDIT_W'(`HUSKY_FIFO_DEPTH);
         sample_valid_o <= 1'b0;
      end else begin
         sample_valid_o <= take;
         case ({credit_return_i, take})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;   // both or neither
         endcase
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      sample_data_o <= adc_data_i[11:4];   // upper byte only
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) heartbeat <= '0;
      else heartbeat <= heartbeat + 1'b1;
   end

   assign led_armed_o = (state == capture_pkg::ARMED);
   assign led_cap_o   = (state == capture_pkg::CAPTURE);
   assign led_err_o   = overflow && heartbeat[`HUSKY_HEARTBEAT_BIT];

   always_comb begin
      reg_datao_o = 8'h00;
      case (reg_address_i)
         usb_reg_pkg::REG_SAMPLES: begin
            if (reg_bytecnt_i == 0) reg_datao_o = num_samples[7:0];
            else if (reg_bytecnt_i == 1) reg_datao_o = num_samples[15:8];
         end
         usb_reg_pkg::REG_STATUS:
            reg_datao_o = {4'h0, overflow, state == capture_pkg::DONE,
                           led_cap_o, led_armed_o};
         default: reg_datao_o = 8'h00;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/sample_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "husky_macros.svh"

module sample_fifo (
   input  wire        clk_usb_buf,
   input  wire        rst_i,
   input  wire  [7:0] reg_address_i,
   input  wire        reg_read_i,
   output logic [7:0] reg_datao_o,
   input  wire        sample_valid_i,
   input  wire  [7:0] sample_data_i,
   output logic       credit_return_o
);

   localparam int ptr_w = $clog2(`HUSKY_FIFO_DEPTH);

   logic [7:0]       mem [`HUSKY_FIFO_DEPTH];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w:0]   count;
   logic             fifo_sel;
   logic             empty;
   logic             pop;

   assign fifo_sel = (reg_address_i == usb_reg_pkg::REG_FIFO_DATA);
   assign empty    = (count == '0);
   assign pop      = reg_read_i && fifo_sel && !empty;   // empty reads return no credit

   // the credit scheme keeps writes off a full FIFO
   always_ff @(posedge clk_usb_buf) begin
      if (sample_valid_i) mem[wr_ptr] <= sample_data_i;
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         wr_ptr          <= '0;
         rd_ptr          <= '0;
         count           <= '0;
         credit_return_o <= 1'b0;
      end else begin
         credit_return_o <= pop;
         if (sample_valid_i) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({sample_valid_i, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head entry shown while addressed
   assign reg_datao_o = (fifo_sel && !empty) ? mem[rd_ptr] : 8'h00;

endmodule

`default_nettype wire

// ==== src/husky_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "husky_macros.svh"

module husky_top (
   input  wire         clk_usb_buf,
   input  wire         rst_i,
   input  wire  [7:0]  usb_addr_i,
   input  wire  [7:0]  usb_data_i,
   output logic [7:0]  usb_data_o,
   output logic        usb_data_oe_o,
   input  wire         usb_rdn_i,
   input  wire         usb_wrn_i,
   input  wire         usb_cen_i,
   input  wire         usb_alen_i,
   input  wire  [3:0]  target_io_i,
   input  wire  [11:0] adc_data_i,
   output logic        trigger_o,
   output logic        led_armed_o,
   output logic        led_cap_o,
   output logic        led_err_o
);

   logic [7:0]                     reg_address;
   logic [`HUSKY_BYTECNT_SIZE-1:0] reg_bytecnt;
   logic [7:0]                     write_data;
   logic [7:0]                     read_data;
   logic                           reg_read;
   logic                           reg_write;
   logic [7:0]                     read_data_trig;
   logic [7:0]                     read_data_cap;
   logic [7:0]                     read_data_fifo;
   logic                           sample_valid;
   logic [7:0]                     sample_data;
   logic                           credit_return;

   // blocks drive zero when not addressed
   assign read_data = read_data_trig | read_data_cap | read_data_fifo;

   usb_reg_main U_usb_reg_main (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .usb_alen_i    (usb_alen_i),
      .reg_address_o (reg_address),
      .reg_bytecnt_o (reg_bytecnt),
      .reg_datao_o   (write_data),
      .reg_datai_i   (read_data),
      .reg_read_o    (reg_read),
      .reg_write_o   (reg_write)
   );

   reg_trigger U_reg_trigger (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .reg_address_i (reg_address),
      .reg_datai_i   (write_data),
      .reg_write_i   (reg_write),
      .reg_datao_o   (read_data_trig),
      .target_io_i   (target_io_i),
      .trigger_o     (trigger_o)
   );

   capture_ctrl U_capture_ctrl (
      .clk_usb_buf     (clk_usb_buf),
      .rst_i           (rst_i),
      .reg_address_i   (reg_address),
      .reg_bytecnt_i   (reg_bytecnt),
      .reg_datai_i     (write_data),
      .reg_write_i     (reg_write),
      .reg_datao_o     (read_data_cap),
      .trigger_i       (trigger_o),
      .adc_data_i      (adc_data_i),
      .sample_valid_o  (sample_valid),
      .sample_data_o   (sample_data),
      .credit_return_i (credit_return),
      .led_armed_o     (led_armed_o),
      .led_cap_o       (led_cap_o),
      .led_err_o       (led_err_o)
   );

   sample_fifo U_sample_fifo (
      .clk_usb_buf     (clk_usb_buf),
      .rst_i           (rst_i),
      .reg_address_i   (reg_address),
      .reg_read_i      (reg_read),
      .reg_datao_o     (read_data_fifo),
      .sample_valid_i  (sample_valid),
      .sample_data_i   (sample_data),
      .credit_return_o (credit_return)
   );

endmodule

`default_nettype wire

// ==== dv/tb_husky.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "husky_macros.svh"

module tb_husky;

   // about 1600 cycles of bus traffic in total, run limit is about twice that
   localparam int watchdog_cycles = 4000;

   logic        clk_usb_buf;
   logic        rst_i;
   logic [7:0]  usb_addr_i;
   logic [7:0]  usb_data_i;
   logic [7:0]  usb_data_o;
   logic        usb_data_oe_o;
   logic        usb_rdn_i;
   logic        usb_wrn_i;
   logic        usb_cen_i;
   logic        usb_alen_i;
   logic [3:0]  target_io_i;
   logic [11:0] adc_data_i;
   logic        trigger_o;
   logic        led_armed_o;
   logic        led_cap_o;
   logic        led_err_o;

   logic [31:0] rng;

   husky_top UUT (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .usb_alen_i    (usb_alen_i),
      .target_io_i   (target_io_i),
      .adc_data_i    (adc_data_i),
      .trigger_o     (trigger_o),
      .led_armed_o   (led_armed_o),
      .led_cap_o     (led_cap_o),
      .led_err_o     (led_err_o)
   );

   always #2 clk_usb_buf = ~clk_usb_buf;   // 4 ns period

   // adc ramp, one step per cycle
   always @(posedge clk_usb_buf) adc_data_i <= adc_data_i + 12'd1;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // expected trigger for a given io pattern, mask and mode
   function automatic logic ref_trigger(input logic [3:0] io, input logic [3:0] mask,
                                        input capture_pkg::trig_mode_e mode);
      if (mask == 4'h0) return 1'b0;
      if (mode == capture_pkg::TRIG_AND) return ((io & mask) == mask);
      return |(io & mask);
   endfunction

   // status byte: bit0 armed, bit1 capturing, bit2 done, bit3 overflow
   function automatic logic [7:0] ref_status(input capture_pkg::cap_state_e st,
                                             input logic ovf);
      return {4'h0, ovf, st == capture_pkg::DONE, st == capture_pkg::CAPTURE,
              st == capture_pkg::ARMED};
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1, "stopping at first failure");
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp)
         abort_run($sformatf("ERROR %s: expected %0h, actual %0h", name, exp, act));
   endtask

   // address phase, clears the byte count
   task automatic set_addr(input logic [7:0] addr);
      @(posedge clk_usb_buf);
      usb_addr_i <= addr;
      usb_alen_i <= 1'b0;
      repeat (2) @(posedge clk_usb_buf);
      usb_alen_i <= 1'b1;
      repeat (2) @(posedge clk_usb_buf);
   endtask

   task automatic write_byte(input logic [7:0] data);
      @(posedge clk_usb_buf);
      usb_data_i <= data;
      usb_cen_i  <= 1'b0;
      usb_wrn_i  <= 1'b0;
      repeat (4) begin
         @(negedge clk_usb_buf);
         check("data_oe during write", 0, usb_data_oe_o);
         @(posedge clk_usb_buf);
      end
      usb_wrn_i <= 1'b1;
      usb_cen_i <= 1'b1;
      repeat (4) @(posedge clk_usb_buf);
   endtask

   task automatic read_byte(output logic [7:0] data);
      @(posedge clk_usb_buf);
      usb_cen_i <= 1'b0;
      usb_rdn_i <= 1'b0;
      repeat (3) @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);   // data out registered by now
      check("data_oe during read", 1, usb_data_oe_o);
      data = usb_data_o;
      @(posedge clk_usb_buf);
      usb_rdn_i <= 1'b1;
      usb_cen_i <= 1'b1;
      repeat (4) @(posedge clk_usb_buf);
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      set_addr(addr);
      write_byte(data);
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
      set_addr(addr);
      read_byte(data);
   endtask

   task automatic set_io(input logic [3:0] io);
      @(posedge clk_usb_buf);
      target_io_i <= io;
      repeat (3) @(posedge clk_usb_buf);
   endtask

   // poll status until the done bit shows up
   task automatic wait_done(output logic [7:0] status);
      int tries;
      tries = 0;
      status = 8'h00;
      set_addr(usb_reg_pkg::REG_STATUS);
      while (status[2] == 1'b0) begin
         if (tries == 40) abort_run("capture never reached the DONE state");
         read_byte(status);
         tries++;
      end
   endtask

   // reads n samples, upper ramp byte may step up once at most
   task automatic drain_fifo(input string name, input int n);
      logic [7:0] prev;
      logic [7:0] got;
      logic [7:0] exp;
      logic       stepped;
      stepped = 1'b0;
      set_addr(usb_reg_pkg::REG_FIFO_DATA);
      read_byte(prev);
      for (int i = 1; i < n; i++) begin
         read_byte(got);
         if (!stepped && got != prev) exp = 8'(prev + 8'd1);
         else exp = prev;
         check($sformatf("%s sample %0d", name, i), exp, got);
         stepped = stepped | (got != prev);
         prev = got;
      end
      read_byte(got);
      check({name, " read of empty fifo"}, 0, got);
   endtask

   task automatic run_capture(input logic [15:0] count, input logic ovf, input string name);
      logic [7:0] status;
      set_io(4'h0);
      bus_write(usb_reg_pkg::REG_TRIG_SRC, 8'h02);   // io1 only
      bus_write(usb_reg_pkg::REG_TRIG_MODE, 8'h00);
      set_addr(usb_reg_pkg::REG_SAMPLES);
      write_byte(count[7:0]);
      write_byte(count[15:8]);
      bus_write(usb_reg_pkg::REG_ARM, 8'h01);
      @(negedge clk_usb_buf);
      check({name, " leds when armed"}, 3'b100, {led_armed_o, led_cap_o, led_err_o});
      set_io(4'h2);
      @(negedge clk_usb_buf);   // capture runs for count cycles from here
      check({name, " leds when capturing"}, 3'b010, {led_armed_o, led_cap_o, led_err_o});
      wait_done(status);
      check({name, " status"}, ref_status(capture_pkg::DONE, ovf), status);
   endtask

   initial begin
      logic [7:0]  rd;
      logic [7:0]  val;
      logic [15:0] cnt;
      logic [3:0]  mask;
      logic [3:0]  io;
      capture_pkg::trig_mode_e mode;

      clk_usb_buf = 1'b0;
      rst_i       = 1'b1;
      usb_addr_i  = 8'h00;
      usb_data_i  = 8'h00;
      usb_rdn_i   = 1'b1;
      usb_wrn_i   = 1'b1;
      usb_cen_i   = 1'b1;
      usb_alen_i  = 1'b1;
      target_io_i = 4'h0;
      adc_data_i  = 12'h000;
      rng         = 32'h7fa2fd2f;

      repeat (4) @(posedge clk_usb_buf);
      rst_i <= 1'b0;

      // reset state
      @(negedge clk_usb_buf);
      check("data_oe after reset", 0, usb_data_oe_o);
      check("trigger after reset", 0, trigger_o);
      check("leds after reset", 0, {led_armed_o, led_cap_o, led_err_o});
      bus_read(usb_reg_pkg::REG_STATUS, rd);
      check("status after reset", ref_status(capture_pkg::IDLE, 1'b0), rd);
      bus_read(usb_reg_pkg::REG_FIFO_DATA, rd);
      check("fifo after reset", 0, rd);

      // register readback
      for (int i = 0; i < 4; i++) begin
         rng = xorshift(rng);
         val = rng[7:0];
         bus_write(usb_reg_pkg::REG_TRIG_SRC, val);
         bus_read(usb_reg_pkg::REG_TRIG_SRC, rd);
         check("trig_src readback", {4'h0, val[3:0]}, rd);
         bus_write(usb_reg_pkg::REG_TRIG_MODE, rng[15:8]);
         bus_read(usb_reg_pkg::REG_TRIG_MODE, rd);
         check("trig_mode readback", {7'h00, rng[8]}, rd);
         cnt = rng[31:16];
         set_addr(usb_reg_pkg::REG_SAMPLES);
         write_byte(cnt[7:0]);
         write_byte(cnt[15:8]);
         set_addr(usb_reg_pkg::REG_SAMPLES);
         read_byte(rd);
         check("samples low byte", cnt[7:0], rd);
         read_byte(rd);
         check("samples high byte", cnt[15:8], rd);
      end

      // trigger combiner
      for (int i = 0; i < 20; i++) begin
         rng  = xorshift(rng);
         io   = rng[3:0];
         mask = rng[7:4];
         mode = capture_pkg::trig_mode_e'(rng[8]);
         bus_write(usb_reg_pkg::REG_TRIG_SRC, {4'h0, mask});
         bus_write(usb_reg_pkg::REG_TRIG_MODE, {7'h00, mode});
         set_io(io);
         @(negedge clk_usb_buf);
         check($sformatf("trigger pattern %0d", i), ref_trigger(io, mask, mode), trigger_o);
      end

      // short capture, fits in the fifo
      run_capture(16'd10, 1'b0, "capture 10");
      drain_fifo("capture 10", 10);

      // longer than the fifo, credits run out
      run_capture(16'd24, 1'b1, "capture 24");
      drain_fifo("capture 24", `HUSKY_FIFO_DEPTH);

      set_io(4'h0);
      bus_write(usb_reg_pkg::REG_ARM, 8'h01);
      bus_read(usb_reg_pkg::REG_STATUS, rd);
      check("status after re-arm", ref_status(capture_pkg::ARMED, 1'b0), rd);

      $display("TESTS PASSED");
      $finish;
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk_usb_buf);
      $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/usb_reg_pkg.sv
src/capture_pkg.sv
src/usb_reg_main.sv
src/reg_trigger.sv
src/capture_ctrl.sv
src/sample_fifo.sv
src/husky_top.sv
dv/tb_husky.sv
